// ==== branch_pkg.sv ====
// Shared definitions for the branch execution stage.
// Holds the address width, the operation and control-flow encodings,
// the misaligned-fetch cause code and the conditional-branch helper.
// Every design file refers to these by scoped name.

`default_nettype none

package branch_pkg;

  // width of pc, operands, immediate and every address in the stage
  localparam int unsigned VLEN = 32;

  // exception cause field width and the one cause this stage can raise
  localparam int unsigned EXC_CAUSE_W = 4;
  localparam logic [EXC_CAUSE_W-1:0] EXC_INSTR_ADDR_MISALIGNED = 4'd0;

  // operations handled by the branch unit
  // the six conditional branches come first, then the two jumps
  typedef enum logic [3:0] {
    BEQ  = 4'd0,
    BNE  = 4'd1,
    BLT  = 4'd2,
    BGE  = 4'd3,
    BLTU = 4'd4,
    BGEU = 4'd5,
    JAL  = 4'd6,
    JALR = 4'd7
  } fu_op_e;

  // control-flow kind, shared by the front-end prediction and the resolution
  typedef enum logic [2:0] {
    NO_CF  = 3'd0,
    BRANCH = 3'd1,
    JUMP   = 3'd2,
    JUMP_R = 3'd3,
    RETURN = 3'd4
  } cf_e;

  // true for the conditional operations, false for JAL and JALR
  function automatic logic op_is_branch(input fu_op_e op);
    logic is_br;
    case (op)
      BEQ, BNE, BLT, BGE, BLTU, BGEU: is_br = 1'b1;
      default: is_br = 1'b0;
    endcase
    return is_br;
  endfunction

endpackage

`default_nettype wire

// ==== branch_compare.sv ====
// Operand comparator of the branch stage.
// Decides whether the instruction transfers control: the comparison
// result for conditional branches, always taken for JAL and JALR.
// Purely combinational.

`timescale 1ns/1ps
`default_nettype none

module branch_compare (
  input  branch_pkg::fu_op_e           op_i,
  input  logic [branch_pkg::VLEN-1:0]  operand_a_i,
  input  logic [branch_pkg::VLEN-1:0]  operand_b_i,
  output logic                         taken_o
);

  // the three basic relations, each evaluated once
  logic equal;
  logic less_signed;
  logic less_unsigned;
  logic cond_result;

  assign equal         = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  // pick the relation that the branch asks for
  // the ge forms are the inverse of the matching lt forms
  always_comb begin
    case (op_i)
      branch_pkg::BEQ:  cond_result = equal;
      branch_pkg::BNE:  cond_result = ~equal;
      branch_pkg::BLT:  cond_result = less_signed;
      branch_pkg::BGE:  cond_result = ~less_signed;
      branch_pkg::BLTU: cond_result = less_unsigned;
      branch_pkg::BGEU: cond_result = ~less_unsigned;
      default:          cond_result = 1'b0;
    endcase
  end

  // jumps always redirect, so the resolver only has to look at one signal
  assign taken_o = branch_pkg::op_is_branch(op_i) ? cond_result : 1'b1;

endmodule

`default_nettype wire

// ==== branch_target.sv ====
// Target and link address unit of the branch stage.
// Adds the sign-extended immediate to pc, or to rs1 for JALR, and
// computes the return address from the instruction length.
// Purely combinational.

`timescale 1ns/1ps
`default_nettype none

module branch_target (
  input  branch_pkg::fu_op_e           op_i,
  input  logic [branch_pkg::VLEN-1:0]  pc_i,
  input  logic [branch_pkg::VLEN-1:0]  operand_a_i,
  input  logic [branch_pkg::VLEN-1:0]  imm_i,
  input  logic                         is_compressed_i,
  output logic [branch_pkg::VLEN-1:0]  target_o,
  output logic [branch_pkg::VLEN-1:0]  next_pc_o
);

  logic                        is_jalr;
  logic [branch_pkg::VLEN-1:0] jump_base;
  logic [branch_pkg::VLEN-1:0] sum;
  logic [2:0]                  instr_len;

  assign is_jalr = (op_i == branch_pkg::JALR);

  // JALR jumps relative to the register, everything else relative to pc
  assign jump_base = is_jalr ? operand_a_i : pc_i;

  // the immediate arrives already sign extended to full width,
  // so a signed add of equal widths gives the wrapped target
  assign sum = $unsigned($signed(jump_base) + $signed(imm_i));

  // JALR ignores the lowest target bit, as the ISA specifies
  always_comb begin
    target_o = sum;
    if (is_jalr) begin
      target_o[0] = 1'b0;
    end
  end

  // link address is the following instruction
  // compressed instructions are 2 bytes long, the rest 4
  assign instr_len = is_compressed_i ? 3'd2 : 3'd4;
  assign next_pc_o = pc_i + {{(branch_pkg::VLEN-3){1'b0}}, instr_len};

endmodule

`default_nettype wire

// ==== branch_resolve.sv ====
// Resolution stage of the branch unit.
// Combines the taken decision and the addresses with the front-end
// prediction, decides mispredict, control-flow kind and the
// misaligned-fetch exception, and registers everything for one cycle.
// Results are valid exactly one cycle after valid_i is sampled.

`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 valid_i,
  input  branch_pkg::fu_op_e                   op_i,
  input  logic [branch_pkg::VLEN-1:0]          pc_i,
  input  logic                                 taken_i,
  input  logic [branch_pkg::VLEN-1:0]          target_i,
  input  logic [branch_pkg::VLEN-1:0]          next_pc_i,
  input  branch_pkg::cf_e                      predict_cf_i,
  input  logic [branch_pkg::VLEN-1:0]          predict_address_i,
  output logic                                 resolve_valid_o,
  output logic [branch_pkg::VLEN-1:0]          resolve_pc_o,
  output logic [branch_pkg::VLEN-1:0]          resolve_target_o,
  output logic                                 resolve_taken_o,
  output logic                                 resolve_mispredict_o,
  output branch_pkg::cf_e                      resolve_cf_o,
  output logic [branch_pkg::VLEN-1:0]          link_o,
  output logic                                 exc_valid_o,
  output logic [branch_pkg::EXC_CAUSE_W-1:0]   exc_cause_o,
  output logic [branch_pkg::VLEN-1:0]          exc_tval_o
);

  logic                        mispredict_d;
  branch_pkg::cf_e             cf_d;
  logic [branch_pkg::VLEN-1:0] redirect_d;
  logic                        misaligned_d;

  // a taken instruction goes to its target, a fall-through to pc + len
  assign redirect_d = taken_i ? target_i : next_pc_i;

  // mispredicts come only from conditional branches and register jumps
  always_comb begin
    mispredict_d = 1'b0;
    // by default the resolution repeats what the front end predicted
    cf_d         = predict_cf_i;
    if (branch_pkg::op_is_branch(op_i)) begin
      // conditional branches always report BRANCH so the history table updates
      cf_d         = branch_pkg::BRANCH;
      // predicted taken means the front end flagged it as BRANCH
      mispredict_d = (taken_i != (predict_cf_i == branch_pkg::BRANCH));
    end else if (op_i == branch_pkg::JALR) begin
      // a register jump is wrong if it was not predicted at all,
      // or if the predicted address does not match the computed one
      if ((predict_cf_i == branch_pkg::NO_CF) || (target_i != predict_address_i)) begin
        mispredict_d = 1'b1;
        // returns keep their kind, so the target buffer is not polluted
        if (predict_cf_i != branch_pkg::RETURN) begin
          cf_d = branch_pkg::JUMP_R;
        end
      end
    end
  end

  // a taken transfer to an odd address cannot be fetched
  // JALR clears bit 0 itself, so in practice this hits branches and JAL
  assign misaligned_d = taken_i & target_i[0];

  // control flags, cleared by reset and qualified by valid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resolve_valid_o      <= 1'b0;
      resolve_mispredict_o <= 1'b0;
      exc_valid_o          <= 1'b0;
    end else begin
      resolve_valid_o      <= valid_i;
      resolve_mispredict_o <= valid_i & mispredict_d;
      exc_valid_o          <= valid_i & misaligned_d;
    end
  end

  // payload, captured only for a valid instruction
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      resolve_pc_o     <= pc_i;
      resolve_target_o <= redirect_d;
      resolve_taken_o  <= taken_i;
      resolve_cf_o     <= cf_d;
      link_o           <= next_pc_i;
      exc_cause_o      <= branch_pkg::EXC_INSTR_ADDR_MISALIGNED;
      // tval is the faulting instruction's pc, XLEN equals VLEN here
      exc_tval_o       <= pc_i;
    end
  end

endmodule

`default_nettype wire

// ==== branch_exec_unit.sv ====
// Branch execution stage, top level.
// One instruction per cycle enters with valid_i; its resolution, link
// address and any misaligned-fetch exception appear one cycle later.
// No back-pressure, the consumer takes each result in its cycle.

`timescale 1ns/1ps
`default_nettype none

module branch_exec_unit (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 valid_i,
  input  branch_pkg::fu_op_e                   op_i,
  input  logic [branch_pkg::VLEN-1:0]          pc_i,
  input  logic [branch_pkg::VLEN-1:0]          operand_a_i,
  input  logic [branch_pkg::VLEN-1:0]          operand_b_i,
  input  logic [branch_pkg::VLEN-1:0]          imm_i,
  input  logic                                 is_compressed_i,
  input  branch_pkg::cf_e                      predict_cf_i,
  input  logic [branch_pkg::VLEN-1:0]          predict_address_i,
  output logic                                 resolve_valid_o,
  output logic [branch_pkg::VLEN-1:0]          resolve_pc_o,
  output logic [branch_pkg::VLEN-1:0]          resolve_target_o,
  output logic                                 resolve_taken_o,
  output logic                                 resolve_mispredict_o,
  output branch_pkg::cf_e                      resolve_cf_o,
  output logic [branch_pkg::VLEN-1:0]          link_o,
  output logic                                 exc_valid_o,
  output logic [branch_pkg::EXC_CAUSE_W-1:0]   exc_cause_o,
  output logic [branch_pkg::VLEN-1:0]          exc_tval_o
);

  // combinational results feeding the register stage
  logic                        taken_w;
  logic [branch_pkg::VLEN-1:0] target_w;
  logic [branch_pkg::VLEN-1:0] next_pc_w;

  // comparator and adder work side by side in the same cycle
  branch_compare u_compare (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .taken_o     (taken_w)
  );

  branch_target u_target (
    .op_i            (op_i),
    .pc_i            (pc_i),
    .operand_a_i     (operand_a_i),
    .imm_i           (imm_i),
    .is_compressed_i (is_compressed_i),
    .target_o        (target_w),
    .next_pc_o       (next_pc_w)
  );

  // the resolver holds all decisions and the only register stage
  branch_resolve u_resolve (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .valid_i              (valid_i),
    .op_i                 (op_i),
    .pc_i                 (pc_i),
    .taken_i              (taken_w),
    .target_i             (target_w),
    .next_pc_i            (next_pc_w),
    .predict_cf_i         (predict_cf_i),
    .predict_address_i    (predict_address_i),
    .resolve_valid_o      (resolve_valid_o),
    .resolve_pc_o         (resolve_pc_o),
    .resolve_target_o     (resolve_target_o),
    .resolve_taken_o      (resolve_taken_o),
    .resolve_mispredict_o (resolve_mispredict_o),
    .resolve_cf_o         (resolve_cf_o),
    .link_o               (link_o),
    .exc_valid_o          (exc_valid_o),
    .exc_cause_o          (exc_cause_o),
    .exc_tval_o           (exc_tval_o)
  );

endmodule

`default_nettype wire

// ==== tb_branch_exec_unit.sv ====
// Directed testbench for the branch execution stage.
// Each test task drives instructions 1 ns after the rising edge, predicts the
// resolution from the branch rules and checks the registered outputs one
// cycle later. Operands come from an xorshift generator with a fixed seed.

`timescale 1ns/1ps
`default_nettype none

module tb_branch_exec_unit;

  localparam int unsigned W = branch_pkg::VLEN;
  localparam int WAIT_LIMIT = 20;

  // one expected result, queued at issue and consumed when the result shows up
  typedef struct packed {
    logic [W-1:0]    pc;
    logic [W-1:0]    target;
    logic            taken;
    logic            mispredict;
    branch_pkg::cf_e cf;
    logic [W-1:0]    link;
    logic            exc;
  } expect_t;

  logic clk_i;
  logic rst_n_i;
  logic valid_i;
  branch_pkg::fu_op_e op_i;
  logic [W-1:0] pc_i;
  logic [W-1:0] operand_a_i;
  logic [W-1:0] operand_b_i;
  logic [W-1:0] imm_i;
  logic is_compressed_i;
  branch_pkg::cf_e predict_cf_i;
  logic [W-1:0] predict_address_i;
  logic resolve_valid_o;
  logic [W-1:0] resolve_pc_o;
  logic [W-1:0] resolve_target_o;
  logic resolve_taken_o;
  logic resolve_mispredict_o;
  branch_pkg::cf_e resolve_cf_o;
  logic [W-1:0] link_o;
  logic exc_valid_o;
  logic [branch_pkg::EXC_CAUSE_W-1:0] exc_cause_o;
  logic [W-1:0] exc_tval_o;

  expect_t exp_q[$];
  logic [31:0] rng_state;
  int errors;
  int test_start_errors;
  int tests_passed;
  int tests_failed;
  branch_pkg::fu_op_e all_ops[8];
  branch_pkg::cf_e cf_kinds[4];

  // port names match the testbench signals one to one
  branch_exec_unit UUT (.*);

  always #4 clk_i = ~clk_i;

  // xorshift32 step on the shared generator state
  function automatic logic [31:0] rand_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_addr(input string name, input logic [W-1:0] exp, input logic [W-1:0] act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cf(input string name, input branch_pkg::cf_e exp,
                          input branch_pkg::cf_e act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %s actual %s", $time, name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_cause(input string name, input logic [branch_pkg::EXC_CAUSE_W-1:0] exp,
                             input logic [branch_pkg::EXC_CAUSE_W-1:0] act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // reference resolution, written from the stage's rules
  function automatic expect_t model_instr(input branch_pkg::fu_op_e op, input logic [W-1:0] pc,
    input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] imm, input logic comp,
    input branch_pkg::cf_e pcf, input logic [W-1:0] paddr);
    expect_t e;
    logic [W-1:0] tgt;
    case (op)
      branch_pkg::BEQ:  e.taken = (a == b);
      branch_pkg::BNE:  e.taken = (a != b);
      branch_pkg::BLT:  e.taken = ($signed(a) < $signed(b));
      branch_pkg::BGE:  e.taken = ($signed(a) >= $signed(b));
      branch_pkg::BLTU: e.taken = (a < b);
      branch_pkg::BGEU: e.taken = (a >= b);
      default:          e.taken = 1'b1;
    endcase
    tgt = ((op == branch_pkg::JALR) ? a : pc) + imm;
    if (op == branch_pkg::JALR) begin
      tgt[0] = 1'b0;
    end
    e.pc = pc;
    e.link = pc + W'(comp ? 2 : 4);
    e.target = e.taken ? tgt : e.link;
    e.cf = pcf;
    e.mispredict = 1'b0;
    if (op != branch_pkg::JAL && op != branch_pkg::JALR) begin
      e.cf = branch_pkg::BRANCH;
      e.mispredict = (e.taken != (pcf == branch_pkg::BRANCH));
    end else if (op == branch_pkg::JALR && (pcf == branch_pkg::NO_CF || tgt != paddr)) begin
      e.mispredict = 1'b1;
      if (pcf != branch_pkg::RETURN) begin
        e.cf = branch_pkg::JUMP_R;
      end
    end
    e.exc = e.taken & tgt[0];
    return e;
  endfunction

  task automatic drive_instr(input branch_pkg::fu_op_e op, input logic [W-1:0] pc,
    input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] imm, input logic comp,
    input branch_pkg::cf_e pcf, input logic [W-1:0] paddr);
    valid_i = 1'b1;
    op_i = op;
    pc_i = pc;
    operand_a_i = a;
    operand_b_i = b;
    imm_i = imm;
    is_compressed_i = comp;
    predict_cf_i = pcf;
    predict_address_i = paddr;
    exp_q.push_back(model_instr(op, pc, a, b, imm, comp, pcf, paddr));
  endtask

  task automatic check_result();
    expect_t e;
    e = exp_q.pop_front();
    check_addr("resolve_pc_o", e.pc, resolve_pc_o);
    check_addr("resolve_target_o", e.target, resolve_target_o);
    check_bit("resolve_taken_o", e.taken, resolve_taken_o);
    check_bit("resolve_mispredict_o", e.mispredict, resolve_mispredict_o);
    check_cf("resolve_cf_o", e.cf, resolve_cf_o);
    check_addr("link_o", e.link, link_o);
    check_bit("exc_valid_o", e.exc, exc_valid_o);
    if (e.exc) begin
      check_cause("exc_cause_o", 4'd0, exc_cause_o);
      check_addr("exc_tval_o", e.pc, exc_tval_o);
    end
  endtask

  // issues one instruction, then waits edge by edge for its result
  task automatic run_one(input branch_pkg::fu_op_e op, input logic [W-1:0] pc,
    input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] imm, input logic comp,
    input branch_pkg::cf_e pcf, input logic [W-1:0] paddr);
    int cycles;
    @(posedge clk_i);
    #1;
    drive_instr(op, pc, a, b, imm, comp, pcf, paddr);
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      valid_i = 1'b0;
      cycles++;
    end while (!resolve_valid_o && cycles < WAIT_LIMIT);
    if (!resolve_valid_o) begin
      $display("resolve_valid_o never rose within %0d cycles of issue", WAIT_LIMIT);
      errors++;
      exp_q.delete();
    end else begin
      if (cycles != 1) begin
        $display("result arrived %0d cycles after issue instead of 1", cycles);
        errors++;
      end
      check_result();
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  task automatic test_reset();
    // a valid, mispredicted and misaligned branch sits on the inputs during reset,
    // so the flags stay low only if the reset holds them
    valid_i = 1'b1;
    op_i = branch_pkg::BEQ;
    operand_a_i = '0;
    operand_b_i = '0;
    imm_i = 32'h0000_0015;
    predict_cf_i = branch_pkg::NO_CF;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      #1;
      check_bit("resolve_valid_o", 1'b0, resolve_valid_o);
      check_bit("resolve_mispredict_o", 1'b0, resolve_mispredict_o);
      check_bit("exc_valid_o", 1'b0, exc_valid_o);
    end
    rst_n_i = 1'b1;
    valid_i = 1'b0;
    // the first edges out of reset are idle, so nothing may be reported
    for (int i = 0; i < 2; i++) begin
      @(posedge clk_i);
      #1;
      check_bit("resolve_valid_o", 1'b0, resolve_valid_o);
      check_bit("resolve_mispredict_o", 1'b0, resolve_mispredict_o);
      check_bit("exc_valid_o", 1'b0, exc_valid_o);
    end
    finish_test("reset");
  endtask

  task automatic test_branches();
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [31:0] r;
    for (int k = 0; k < 6; k++) begin
      for (int v = 0; v < 6; v++) begin
        r = rand_word();
        a = rand_word();
        b = rand_word();
        // v / 2 picks random, equal or sign-only-different operands
        if (v / 2 == 1) b = a;
        if (v / 2 == 2) b = a ^ 32'h8000_0000;
        run_one(all_ops[k], r & ~32'h3, a, b, {{20{r[11]}}, r[11:1], 1'b0}, r[12],
                v[0] ? branch_pkg::BRANCH : branch_pkg::NO_CF, '0);
      end
    end
    finish_test("conditional branches");
  endtask

  task automatic test_jal();
    logic [W-1:0] mag;
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r = rand_word();
      mag = {20'd0, r[11:1], 1'b0};
      run_one(branch_pkg::JAL, r & ~32'h3, rand_word(), rand_word(), i[1] ? (~mag + 1) : mag,
              i[0], (i == 3) ? branch_pkg::NO_CF : branch_pkg::JUMP, '0);
      check_bit("resolve_taken_o", 1'b1, resolve_taken_o);
    end
    finish_test("jal");
  endtask

  task automatic test_jalr();
    logic [W-1:0] a;
    logic [W-1:0] imm;
    logic [W-1:0] dest;
    logic [31:0] r;
    for (int i = 0; i < 5; i++) begin
      r = rand_word();
      // an odd base with an even offset gives an odd sum, so bit 0 must be cleared
      a = rand_word() | 32'h1;
      imm = {{20{r[11]}}, r[11:1], 1'b0};
      dest = (a + imm) & ~32'h1;
      case (i)
        0: run_one(branch_pkg::JALR, r & ~32'h3, a, '0, imm, r[12], branch_pkg::JUMP_R, dest);
        1: run_one(branch_pkg::JALR, r & ~32'h3, a, '0, imm, r[12], branch_pkg::JUMP_R, dest + 4);
        2: run_one(branch_pkg::JALR, r & ~32'h3, a, '0, imm, r[12], branch_pkg::NO_CF, dest);
        3: run_one(branch_pkg::JALR, r & ~32'h3, a, '0, imm, r[12], branch_pkg::RETURN, dest ^ 64);
        default: run_one(branch_pkg::JALR, r & ~32'h3, a, '0, imm, r[12], branch_pkg::RETURN, dest);
      endcase
      check_addr("resolve_target_o", dest, resolve_target_o);
    end
    finish_test("jalr");
  endtask

  task automatic test_misaligned();
    logic [W-1:0] pc;
    logic [W-1:0] a;
    pc = rand_word() & ~32'h3;
    a = rand_word();
    // taken branch and JAL to odd targets fault, with tval holding the pc
    run_one(branch_pkg::BEQ, pc, a, a, 32'h0000_0015, 1'b0, branch_pkg::BRANCH, '0);
    check_bit("exc_valid_o", 1'b1, exc_valid_o);
    run_one(branch_pkg::JAL, pc, a, a, 32'hffff_ffe3, 1'b1, branch_pkg::JUMP, '0);
    check_bit("exc_valid_o", 1'b1, exc_valid_o);
    // a fall-through never faults, and JALR drops the odd bit itself
    run_one(branch_pkg::BNE, pc, a, a, 32'h0000_0015, 1'b0, branch_pkg::NO_CF, '0);
    check_bit("exc_valid_o", 1'b0, exc_valid_o);
    run_one(branch_pkg::JALR, pc, a | 32'h1, '0, 32'h0000_0010, 1'b0, branch_pkg::JUMP_R, '0);
    check_bit("exc_valid_o", 1'b0, exc_valid_o);
    finish_test("misaligned target");
  endtask

  task automatic test_back_to_back();
    logic [W-1:0] a;
    logic [W-1:0] imm;
    logic [31:0] r;
    for (int i = 0; i <= 8; i++) begin
      @(posedge clk_i);
      #1;
      // the previous instruction must appear on exactly this edge
      if (i > 0) begin
        if (!resolve_valid_o) begin
          $display("back-to-back result %0d missing one cycle after issue", i - 1);
          errors++;
          exp_q.delete(0);
        end else begin
          check_result();
        end
      end
      if (i < 8) begin
        r = rand_word();
        a = rand_word();
        imm = {{20{r[11]}}, r[11:0]};
        drive_instr(all_ops[r[14:12]], r & ~32'h1, a, rand_word(), imm, r[15],
                    cf_kinds[r[17:16]], r[18] ? ((a + imm) & ~32'h1) : rand_word());
      end else begin
        valid_i = 1'b0;
      end
    end
    finish_test("back-to-back");
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    op_i = branch_pkg::BEQ;
    pc_i = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    imm_i = '0;
    is_compressed_i = 1'b0;
    predict_cf_i = branch_pkg::NO_CF;
    predict_address_i = '0;
    rng_state = 32'h75919458;
    errors = 0;
    test_start_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    all_ops = '{branch_pkg::BEQ, branch_pkg::BNE, branch_pkg::BLT, branch_pkg::BGE,
                branch_pkg::BLTU, branch_pkg::BGEU, branch_pkg::JAL, branch_pkg::JALR};
    cf_kinds = '{branch_pkg::NO_CF, branch_pkg::BRANCH, branch_pkg::JUMP_R, branch_pkg::RETURN};
    test_reset();
    test_branches();
    test_jal();
    test_jalr();
    test_misaligned();
    test_back_to_back();
    $display("tests passed %0d, failed %0d, mismatches %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== branch_exec_unit.f ====
branch_pkg.sv
branch_compare.sv
branch_target.sv
branch_resolve.sv
branch_exec_unit.sv
tb_branch_exec_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the branch stage testbench with Verilator and runs it.
# Exits non-zero on a build error, a simulator error or a failing testbench.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f branch_exec_unit.f --top-module tb_branch_exec_unit -o sim_branch
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_branch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
